//--- source/dspFormatPkg.sv
package dspFormatPkg;

	// Default width of one real input sample, in bits.
	localparam int DEFAULT_DATA_WIDTH = 18;

	// Longest supported filter. The length must be odd so that one tap sits on the center.
	localparam int MAX_TAPS = 27;

	// The coefficients are fixed point with this many fraction bits.
	localparam int COEFF_FRAC_BITS = 16;

	// Quantized Hilbert impulse response for offsets -13 to +13 about index 13.
	// Odd offsets hold round(2 / (pi * offset) * 2^16).
	// Even offsets, the center among them, are zero.
	// The table is antisymmetric, so entry 13 + d is the negative of entry 13 - d.
	// A shorter filter takes the centered slice of this table.
	localparam logic signed [DEFAULT_DATA_WIDTH-1:0] HILBERT_COEFF_TABLE [MAX_TAPS] = '{
		-18'sd3209, 18'sd0, -18'sd3793, 18'sd0,
		-18'sd4636, 18'sd0, -18'sd5960, 18'sd0,
		-18'sd8344, 18'sd0, -18'sd13907, 18'sd0,
		-18'sd41722,
		18'sd0,
		18'sd41722,
		18'sd0, 18'sd13907, 18'sd0, 18'sd8344,
		18'sd0, 18'sd5960, 18'sd0, 18'sd4636,
		18'sd0, 18'sd3793, 18'sd0, 18'sd3209
	};

endpackage

//--- source/hilbertCtrlPkg.sv
package hilbertCtrlPkg;

	// Controller states.
	// Idle waits for enable.
	// Load runs the serial coefficient transfer into the FIR.
	// Stream moves one sample per clock through the filter and the real delay line.
	// Stopped is final; only reset leaves it.
	typedef enum logic [1:0] {
		stateIdle,
		stateLoad,
		stateStream,
		stateStopped
	} htState_t;

	// Clocks from a sample entering the block to its filter result leaving it.
	// One for the input register, one for the product sum register,
	// and one for the output register.
	localparam int FIR_PIPE_LATENCY = 3;

	// The envelope detector adds one registered stage after the analytic pair.
	localparam int ENV_LATENCY = 1;

endpackage

//--- source/hilbertCoeffLoader.sv
module hilbertCoeffLoader #(
	parameter int taps = dspFormatPkg::MAX_TAPS,
	parameter int dataWidth = dspFormatPkg::DEFAULT_DATA_WIDTH
) (
	input  logic                        clock,
	input  logic                        rstN,
	input  logic                        start,
	output logic signed [dataWidth-1:0] coeffOut,
	output logic                        coeffValid,
	output logic                        coeffDone
);
	import dspFormatPkg::*;

	// Index of the table center.
	localparam int CENTER = (MAX_TAPS - 1) / 2;

	// Last table entry of the centered slice; the first is LAST_INDEX - (taps - 1).
	localparam int LAST_INDEX = CENTER + (taps - 1) / 2;

	// Wide enough to hold taps - 1.
	localparam int COUNT_WIDTH = $clog2(taps);

	// Coefficients still to be sent after the one now on coeffOut.
	logic [COUNT_WIDTH-1:0] remaining;
	logic [COUNT_WIDTH-1:0] nextRemaining;
	logic                   accept;

	// A start pulse counts only when the loader is neither sending nor signalling done.
	assign accept = start && !coeffValid && !coeffDone;

	// The counter runs down, so the table index LAST_INDEX - count runs up.
	assign nextRemaining = accept ? COUNT_WIDTH'(taps - 1) : remaining - COUNT_WIDTH'(1);

	// Control side of the transfer.
	// coeffValid stays high for exactly taps clocks.
	// coeffDone follows on the clock after the last coefficient, for one clock.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			coeffValid <= 1'b0;
			coeffDone <= 1'b0;
			remaining <= '0;
		end else begin
			coeffDone <= 1'b0;
			if (accept) begin
				coeffValid <= 1'b1;
				remaining <= nextRemaining;
			end else if (coeffValid) begin
				if (remaining == '0) begin
					// The last coefficient has just been presented.
					coeffValid <= 1'b0;
					coeffDone <= 1'b1;
				end else begin
					remaining <= nextRemaining;
				end
			end
		end
	end

	// Coefficient word for the next clock.
	// It is taken from the table at the index that matches the new count.
	always_ff @(posedge clock) begin
		if (accept || (coeffValid && remaining != '0)) begin
			coeffOut <= dataWidth'(HILBERT_COEFF_TABLE[LAST_INDEX - int'(nextRemaining)]);
		end
	end

endmodule

//--- source/firFilter.sv
module firFilter #(
	parameter int taps = dspFormatPkg::MAX_TAPS,
	parameter int dataWidth = dspFormatPkg::DEFAULT_DATA_WIDTH
) (
	input  logic                          clock,
	input  logic                          rstN,
	input  logic signed [dataWidth-1:0]   coeffIn,
	input  logic                          coeffValid,
	input  logic signed [dataWidth-1:0]   sampleIn,
	input  logic                          run,
	output logic signed [2*dataWidth-1:0] sumOut
);

	localparam int SUM_WIDTH = 2 * dataWidth;

	// Coefficient chain.
	// New words enter at the top and move down, so after taps loads
	// coeffChain[k] holds the k-th coefficient that was sent.
	logic signed [dataWidth-1:0] coeffChain [taps];

	// Sample history.
	// The incoming sample is tap zero, so only taps - 1 older samples are kept.
	// history[0] is the sample from one run clock ago.
	logic signed [dataWidth-1:0] history [taps-1];

	// The taps samples that meet the coefficients, newest first.
	logic signed [dataWidth-1:0] window [taps];

	// One full-width product per tap.
	logic signed [SUM_WIDTH-1:0] products [taps];

	// Sum of all products before the output register.
	logic signed [SUM_WIDTH-1:0] accumulator;

	// Previous coeffValid, used to find the start of a load.
	logic coeffValidQ;
	logic firstCoeff;

	// The first coefficient of a load starts a new filter run with empty history.
	assign firstCoeff = coeffValid && !coeffValidQ;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			coeffValidQ <= 1'b0;
		end else begin
			coeffValidQ <= coeffValid;
		end
	end

	// Serial coefficient load.
	always_ff @(posedge clock) begin
		if (coeffValid) begin
			coeffChain[taps-1] <= coeffIn;
			for (int k = 0; k < taps - 1; k++) begin
				coeffChain[k] <= coeffChain[k+1];
			end
		end
	end

	// Sample shift. The history is cleared when a load begins,
	// which gives the zero start-up of the convolution.
	always_ff @(posedge clock) begin
		if (firstCoeff) begin
			for (int k = 0; k < taps - 1; k++) begin
				history[k] <= '0;
			end
		end else if (run) begin
			history[0] <= sampleIn;
			for (int k = 1; k < taps - 1; k++) begin
				history[k] <= history[k-1];
			end
		end
	end

	// Line up the samples with their taps.
	assign window[0] = sampleIn;

	for (genvar k = 1; k < taps; k++) begin : genWindow
		assign window[k] = history[k-1];
	end

	// Products are taken at the full sum width, so they never overflow.
	for (genvar k = 0; k < taps; k++) begin : genProduct
		assign products[k] = coeffChain[k] * window[k];
	end

	// Adder tree written as a loop.
	// The sum wraps at the output width; the rounded table keeps
	// a full-scale input inside that range.
	always_comb begin
		accumulator = '0;
		for (int k = 0; k < taps; k++) begin
			accumulator += products[k];
		end
	end

	// Registered result.
	// It only moves while samples move, so it holds its value outside streaming.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			sumOut <= '0;
		end else if (run) begin
			sumOut <= accumulator;
		end
	end

endmodule

//--- source/hilbertTransform.sv
module hilbertTransform #(
	parameter int taps = dspFormatPkg::MAX_TAPS,
	parameter int dataWidth = dspFormatPkg::DEFAULT_DATA_WIDTH
) (
	input  logic                          clock,
	input  logic                          rstN,
	input  logic                          enable,
	input  logic                          stopDataIn,
	input  logic signed [dataWidth-1:0]   dataIn,
	output logic signed [2*dataWidth-1:0] dataOutRe,
	output logic signed [2*dataWidth-1:0] dataOutIm,
	output logic                          streaming
);
	import hilbertCtrlPkg::*;

	localparam int OUT_WIDTH = 2 * dataWidth;

	// The real path waits for the filter pipeline and for the group delay
	// of the filter, which is half its length.
	// dataOutRe is the last of these stages, so the line itself is one shorter.
	localparam int REAL_DELAY = FIR_PIPE_LATENCY + (taps - 1) / 2;

	htState_t state;

	// One clock pulse that starts the coefficient transfer.
	logic loaderStart;

	// Loader to FIR.
	logic signed [dataWidth-1:0] coeffOut;
	logic                        coeffValid;
	logic                        coeffDone;

	// Controller to FIR and back.
	logic signed [dataWidth-1:0] firSample;
	logic                        firRun;
	logic signed [OUT_WIDTH-1:0] firSum;

	// Delay line for the real output.
	logic signed [dataWidth-1:0] realLine [REAL_DELAY-1];

	// High on every clock on which a new sample is taken.
	logic streamStep;

	assign streaming = (state == stateStream);

	// The clock that samples stopDataIn already takes no new data.
	assign streamStep = streaming && !stopDataIn;
	assign firRun = streamStep;

	hilbertCoeffLoader #(
		.taps      (taps),
		.dataWidth (dataWidth)
	) u_hilbertCoeffLoader (
		.clock      (clock),
		.rstN       (rstN),
		.start      (loaderStart),
		.coeffOut   (coeffOut),
		.coeffValid (coeffValid),
		.coeffDone  (coeffDone)
	);

	firFilter #(
		.taps      (taps),
		.dataWidth (dataWidth)
	) u_firFilter (
		.clock      (clock),
		.rstN       (rstN),
		.coeffIn    (coeffOut),
		.coeffValid (coeffValid),
		.sampleIn   (firSample),
		.run        (firRun),
		.sumOut     (firSum)
	);

	// Sequencing of the block.
	// Idle to Load issues the loader start on the same edge.
	// Load to Stream follows the loader done pulse.
	// Stream to Stopped follows stopDataIn, and Stopped is never left.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= stateIdle;
			loaderStart <= 1'b0;
		end else begin
			loaderStart <= 1'b0;
			case (state)
				stateIdle: begin
					if (enable) begin
						state <= stateLoad;
						loaderStart <= 1'b1;
					end
				end
				stateLoad: begin
					if (coeffDone) begin
						state <= stateStream;
					end
				end
				stateStream: begin
					if (stopDataIn) begin
						state <= stateStopped;
					end
				end
				stateStopped: begin
					state <= stateStopped;
				end
			endcase
		end
	end

	// Datapath.
	// Both paths start from zero, so the first outputs of a stream are the
	// zero history the filter was cleared to.
	// Outside streaming both outputs are forced to zero.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			firSample <= '0;
			for (int i = 0; i < REAL_DELAY - 1; i++) begin
				realLine[i] <= '0;
			end
			dataOutRe <= '0;
			dataOutIm <= '0;
		end else if (streamStep) begin
			firSample <= dataIn;
			realLine[0] <= dataIn;
			for (int i = 1; i < REAL_DELAY - 1; i++) begin
				realLine[i] <= realLine[i-1];
			end
			// Sign extension to the output width.
			dataOutRe <= OUT_WIDTH'(realLine[REAL_DELAY-2]);
			dataOutIm <= firSum;
		end else begin
			dataOutRe <= '0;
			dataOutIm <= '0;
		end
	end

endmodule

//--- source/envelopeDetector.sv
module envelopeDetector #(
	parameter int dataWidth = dspFormatPkg::DEFAULT_DATA_WIDTH
) (
	input  logic                          clock,
	input  logic                          rstN,
	input  logic signed [2*dataWidth-1:0] re,
	input  logic signed [2*dataWidth-1:0] im,
	output logic        [2*dataWidth:0]   envelope
);

	localparam int IN_WIDTH = 2 * dataWidth;

	// Magnitudes of the two components.
	// The most negative input maps to its exact magnitude as an unsigned word.
	logic [IN_WIDTH-1:0] absRe;
	logic [IN_WIDTH-1:0] absIm;

	// The two magnitudes in order.
	logic [IN_WIDTH-1:0] largest;
	logic [IN_WIDTH-1:0] smallest;

	// Estimate before the output register.
	logic [IN_WIDTH:0] estimate;

	assign absRe = re[IN_WIDTH-1] ? $unsigned(-re) : $unsigned(re);
	assign absIm = im[IN_WIDTH-1] ? $unsigned(-im) : $unsigned(im);

	// Order the pair.
	// On a tie either choice gives the same sum.
	assign largest = (absRe >= absIm) ? absRe : absIm;
	assign smallest = (absRe >= absIm) ? absIm : absRe;

	// Alpha max plus beta min with alpha = 1 and beta = 1/2.
	// The halving is a right shift, so it truncates toward zero.
	// The extra bit holds the carry of the sum.
	assign estimate = {1'b0, largest} + {1'b0, smallest >> 1};

	// One registered stage.
	// A zero analytic pair gives a zero envelope one clock later.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			envelope <= '0;
		end else begin
			envelope <= estimate;
		end
	end

endmodule

//--- source/analyticSignalTop.sv
module analyticSignalTop #(
	parameter int taps = dspFormatPkg::MAX_TAPS,
	parameter int dataWidth = dspFormatPkg::DEFAULT_DATA_WIDTH
) (
	input  logic                          clock,
	input  logic                          rstN,
	input  logic                          enable,
	input  logic                          stopDataIn,
	input  logic signed [dataWidth-1:0]   dataIn,
	output logic signed [2*dataWidth-1:0] dataOutRe,
	output logic signed [2*dataWidth-1:0] dataOutIm,
	output logic        [2*dataWidth:0]   envelope,
	output logic                          streaming
);

	// Analytic signal generator.
	// It owns the coefficient loader and the FIR.
	hilbertTransform #(
		.taps      (taps),
		.dataWidth (dataWidth)
	) u_hilbertTransform (
		.clock      (clock),
		.rstN       (rstN),
		.enable     (enable),
		.stopDataIn (stopDataIn),
		.dataIn     (dataIn),
		.dataOutRe  (dataOutRe),
		.dataOutIm  (dataOutIm),
		.streaming  (streaming)
	);

	// Magnitude estimate of the pair the generator puts out.
	// It lags the pair by one clock.
	envelopeDetector #(
		.dataWidth (dataWidth)
	) u_envelopeDetector (
		.clock    (clock),
		.rstN     (rstN),
		.re       (dataOutRe),
		.im       (dataOutIm),
		.envelope (envelope)
	);

endmodule

//--- verif/hilbertModel.svh
`ifndef HILBERT_MODEL_SVH
`define HILBERT_MODEL_SVH

// Reference model of the analytic signal path.
// It relies on TAPS, DATA_WIDTH and the package constants of the module that includes it.

// Outputs are sampled just after an edge.
// A value due at stream clock n + L is therefore seen after edge n + L - 1.
localparam int IM_LAG = FIR_PIPE_LATENCY - 1;
localparam int RE_LAG = IM_LAG + (TAPS - 1) / 2;

// First table entry of the centered slice that the loader sends.
localparam int FIRST_COEFF = (MAX_TAPS - 1) / 2 - (TAPS - 1) / 2;

// Every sample taken on a stream clock, x[0] first.
longint sampleHistory[$];

function automatic void recordSample(input logic signed [DATA_WIDTH-1:0] sample);
	sampleHistory.push_back(longint'(sample));
endfunction

// The history reads as zero before the stream starts.
function automatic longint sampleAt(input int n);
	if (n < 0 || n >= sampleHistory.size()) begin
		return 0;
	end
	return sampleHistory[n];
endfunction

// Convolution of the samples with the loaded coefficients, c[k] = table[FIRST_COEFF + k].
function automatic longint firExpected(input int n);
	longint sum;
	sum = 0;
	for (int k = 0; k < TAPS; k++) begin
		sum += longint'(HILBERT_COEFF_TABLE[FIRST_COEFF + k]) * sampleAt(n - k);
	end
	return sum;
endfunction

// The real path is a plain delay line, so its output is an older sample.
function automatic longint realExpected(input int n);
	return sampleAt(n);
endfunction

// Larger magnitude plus half of the smaller one.
function automatic longint envelopeExpected(input longint re, input longint im);
	longint absRe;
	longint absIm;
	absRe = (re < 0) ? -re : re;
	absIm = (im < 0) ? -im : im;
	if (absRe >= absIm) begin
		return absRe + (absIm >>> 1);
	end
	return absIm + (absRe >>> 1);
endfunction

`endif

//--- verif/tbHilbert.sv
module tbHilbert;
	import dspFormatPkg::*;
	import hilbertCtrlPkg::*;

	localparam int TAPS = 27;
	localparam int DATA_WIDTH = 18;
	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES = 20;
	localparam int LOAD_LIMIT = TAPS + 4;
	localparam int STREAM_CYCLES = 400;
	localparam int STOP_CYCLES = 30;

	// Clocks spent in the load state, from the edge that takes enable to the edge into streaming.
	localparam int LOAD_CYCLES = TAPS + 2;

	// Every phase of the run, the stop clock and a margin of 50 clocks.
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + LOAD_LIMIT
		+ STREAM_CYCLES + 1 + STOP_CYCLES + 50;

	logic                           clock;
	logic                           rstN;
	logic                           enable;
	logic                           stopDataIn;
	logic signed [DATA_WIDTH-1:0]   dataIn;
	logic signed [2*DATA_WIDTH-1:0] dataOutRe;
	logic signed [2*DATA_WIDTH-1:0] dataOutIm;
	logic        [2*DATA_WIDTH:0]   envelope;
	logic                           streaming;

	logic [DATA_WIDTH-1:0] lfsrState;
	int checkCount;
	int errorCount;
	int failureCount;

	// Expected outputs after the previous edge; the envelope lags them by one clock.
	longint prevRe;
	longint prevIm;

	`include "hilbertModel.svh"

	analyticSignalTop #(
		.taps      (TAPS),
		.dataWidth (DATA_WIDTH)
	) u_analyticSignalTop (
		.clock      (clock),
		.rstN       (rstN),
		.enable     (enable),
		.stopDataIn (stopDataIn),
		.dataIn     (dataIn),
		.dataOutRe  (dataOutRe),
		.dataOutIm  (dataOutIm),
		.envelope   (envelope),
		.streaming  (streaming)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// Fibonacci LFSR with the polynomial x^18 + x^11 + 1, one step per bit.
	function automatic logic lfsrBit();
		logic feedback;
		feedback = lfsrState[17] ^ lfsrState[10];
		lfsrState = {lfsrState[16:0], feedback};
		return feedback;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] randomSample();
		logic [DATA_WIDTH-1:0] value;
		value = '0;
		for (int b = 0; b < DATA_WIDTH; b++) begin
			value = {value[DATA_WIDTH-2:0], lfsrBit()};
		end
		return value;
	endfunction

	task automatic compareValue(input string what, input longint actual, input longint expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error at time %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	// Checks all outputs after one edge and remembers the expected pair for the envelope.
	task automatic checkOutputs(input longint expRe, input longint expIm, input logic expStreaming);
		compareValue("streaming", longint'(streaming), longint'(expStreaming));
		compareValue("dataOutRe", longint'(dataOutRe), expRe);
		compareValue("dataOutIm", longint'(dataOutIm), expIm);
		compareValue("envelope", longint'(envelope), envelopeExpected(prevRe, prevIm));
		prevRe = expRe;
		prevIm = expIm;
	endtask

	// Inputs change one unit after the rising edge, where the outputs are also settled.
	task automatic waitDriveSlot();
		@(posedge clock);
		#1;
	endtask

	initial begin
		int waited;
		bit streamSeen;
		clock = 1'b0;
		rstN = 1'b0;
		enable = 1'b0;
		stopDataIn = 1'b0;
		dataIn = '0;
		lfsrState = DATA_WIDTH'(85);
		checkCount = 0;
		errorCount = 0;
		failureCount = 0;
		prevRe = 0;
		prevIm = 0;
		streamSeen = 1'b0;
		waited = 0;
		repeat (RESET_CYCLES) waitDriveSlot();
		rstN = 1'b1;

		// Idle with enable low. Input data must have no effect.
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			dataIn = randomSample();
			waitDriveSlot();
			checkOutputs(0, 0, 1'b0);
		end

		// One enable pulse starts the coefficient load.
		// The first edge takes enable, and streaming rises after the load clocks that follow it.
		enable = 1'b1;
		while (!streamSeen && waited < LOAD_LIMIT) begin
			waitDriveSlot();
			enable = 1'b0;
			waited++;
			streamSeen = (streaming === 1'b1);
			checkOutputs(0, 0, waited > LOAD_CYCLES);
		end

		if (!streamSeen) begin
			failureCount++;
			$display("The block did not start streaming within %0d clocks after enable.",
				LOAD_LIMIT);
		end else begin
			// Each iteration presents x[n] for stream edge n and checks that edge.
			for (int n = 0; n < STREAM_CYCLES; n++) begin
				dataIn = randomSample();
				recordSample(dataIn);
				waitDriveSlot();
				checkOutputs(realExpected(n - RE_LAG), firExpected(n - IM_LAG), 1'b1);
			end

			// The stop edge already forces the outputs to zero.
			stopDataIn = 1'b1;
			dataIn = randomSample();
			waitDriveSlot();
			stopDataIn = 1'b0;
			checkOutputs(0, 0, 1'b0);

			// Stopped is final, so enable pulses here must not restart the block.
			for (int i = 0; i < STOP_CYCLES; i++) begin
				enable = (i % 7 == 3);
				dataIn = randomSample();
				waitDriveSlot();
				checkOutputs(0, 0, 1'b0);
			end
		end

		$display("Checks: %0d, value errors: %0d, other failures: %0d",
			checkCount, errorCount, failureCount);
		if (errorCount == 0 && failureCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog.
	initial begin
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("The run did not finish within %0d clock cycles and was stopped.",
			TIMEOUT_CYCLES);
		$display("Checks: %0d, value errors: %0d, other failures: %0d",
			checkCount, errorCount, failureCount + 1);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- tb.f
+incdir+verif
source/dspFormatPkg.sv
source/hilbertCtrlPkg.sv
source/hilbertCoeffLoader.sv
source/firFilter.sv
source/hilbertTransform.sv
source/envelopeDetector.sv
source/analyticSignalTop.sv
verif/tbHilbert.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and fail when the log reports a failed test.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tbHilbert -Mdir obj_dir -o simHilbert -f tb.f \
	|| { echo "Verilator build failed."; exit 1; }
./obj_dir/simHilbert > sim.log 2>&1 || echo "The simulator exited with an error."
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
